/* verilog/debug_pkg.sv */
package debug_pkg;

    ////////////////////////////////
    // data widths
    ////////////////////////////////

    typedef logic [31:0] word_t;   // instruction, latch, register, memory word
    typedef logic [7:0]  byte_t;   // one uart data byte

    ////////////////////////////////
    // host commands
    ////////////////////////////////

    localparam byte_t cmd_start      = 8'h01;  // begin programming
    localparam byte_t cmd_continuous = 8'h02;  // run until halt
    localparam byte_t cmd_step_mode  = 8'h03;
    localparam byte_t cmd_reprogram  = 8'h05;  // back to idle
    localparam byte_t cmd_step       = 8'h06;  // one core clock

    // opcode field of the last instruction of a program
    localparam logic [5:0] halt_opcode = 6'b111111;

    ////////////////////////////////
    // dump layout
    ////////////////////////////////

    // pc, if_id, id_ex, ex_mem, mem_wb, cycles
    localparam int dump_header_words = 6;

endpackage

/* verilog/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int clks_per_bit = 868
) (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    output logic tick
);

    localparam int div   = clks_per_bit / 16;  // 16x oversampling
    localparam int cnt_w = $clog2(div) + 1;

    logic [cnt_w-1:0] count;

    assign tick = (count == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= cnt_w'(div - 1);
        end else if (clear || tick) begin
            count <= cnt_w'(div - 1);  // realign or reload
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             rx_line,
    output debug_pkg::byte_t rx_data,
    output logic             rx_done
);

    import debug_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } rx_state_t;

    rx_state_t   state;
    logic [1:0]  sync;
    logic        line_sync;
    logic        tick;
    logic [3:0]  tick_cnt;
    logic [2:0]  bit_cnt;
    byte_t       shift;

    assign line_sync = sync[1];

    baud_tick_gen #(
        .clks_per_bit(clks_per_bit)
    ) u_baud_tick_gen (
        .clk  (clk),
        .reset(reset),
        .clear(state == s_idle),
        .tick (tick)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync     <= 2'b11;  // line idles high
            state    <= s_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_done  <= 1'b0;
        end else begin
            sync    <= {sync[0], rx_line};
            rx_done <= 1'b0;
            case (state)
                s_idle: begin
                    if (!line_sync) begin
                        state    <= s_start;
                        tick_cnt <= '0;
                    end
                end
                s_start: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd7) begin  // mid start bit
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= line_sync ? s_idle : s_data;
                        end
                    end
                end
                s_data: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= s_stop;
                            end
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            rx_done <= line_sync;  // bad stop bit drops the byte
                            state   <= s_idle;
                        end
                    end
                end
            endcase
        end
    end

    // data path, sampled at bit centres
    always_ff @(posedge clk) begin
        if (state == s_data && tick && tick_cnt == 4'd15) begin
            shift <= {line_sync, shift[7:1]};
        end
        if (state == s_stop && tick && tick_cnt == 4'd15 && line_sync) begin
            rx_data <= shift;
        end
    end

    a_rx_done_single: assert property (@(posedge clk) disable iff (reset)
        rx_done |=> !rx_done);

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_bit = 868
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             tx_start,
    input  debug_pkg::byte_t tx_data,
    output logic             tx_line,
    output logic             tx_busy,
    output logic             tx_done
);

    import debug_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } tx_state_t;

    tx_state_t  state;
    logic       tick;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    byte_t      shift;

    baud_tick_gen #(
        .clks_per_bit(clks_per_bit)
    ) u_baud_tick_gen (
        .clk  (clk),
        .reset(reset),
        .clear(state == s_idle),
        .tick (tick)
    );

    assign tx_busy = (state != s_idle);
    assign tx_done = (state == s_stop) && tick && (tick_cnt == 4'd15);
    assign tx_line = (state == s_start) ? 1'b0 :
                     (state == s_data)  ? shift[0] : 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= s_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == s_idle) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            if (tx_start) begin
                state <= s_start;
            end
        end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == 4'd15) begin  // end of a bit
                case (state)
                    s_start: state <= s_data;
                    s_data: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= s_stop;
                        end
                    end
                    default: state <= s_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && tx_start) begin
            shift <= tx_data;
        end else if (state == s_data && tick && tick_cnt == 4'd15) begin
            shift <= shift >> 1;  // lsb first
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy);

endmodule

/* verilog/program_memory.sv */
`timescale 1ns/1ps

module program_memory #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(imem_depth)-1:0] waddr,
    input  debug_pkg::word_t              wdata,
    input  logic [$clog2(imem_depth)-1:0] raddr,
    output debug_pkg::word_t              rdata
);

    import debug_pkg::*;

    word_t mem [imem_depth];

    // write from the debug controller
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // core fetch port, registered
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* verilog/state_collector.sv */
`timescale 1ns/1ps

module state_collector #(
    parameter int num_regs      = 32,
    parameter int num_mem_words = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             collect_restart,
    input  logic             collect_next,
    output logic [4:0]       reg_addr,
    input  debug_pkg::word_t reg_data,
    output debug_pkg::word_t mem_addr,
    input  debug_pkg::word_t mem_data,
    output debug_pkg::word_t collected_word,
    output logic             last_word
);

    import debug_pkg::*;

    localparam int total_words = num_regs + num_mem_words;
    localparam int idx_w       = $clog2(total_words);

    logic [idx_w-1:0] index;
    logic [idx_w-1:0] index_next;
    logic [idx_w-1:0] mem_index;
    logic             in_regs;

    // address the next word already, so the reply lands one cycle later
    always_comb begin
        if (collect_restart) begin
            index_next = '0;
        end else if (collect_next) begin
            index_next = index + 1'b1;
        end else begin
            index_next = index;
        end
    end

    assign in_regs   = (index_next < idx_w'(num_regs));
    assign mem_index = index_next - idx_w'(num_regs);
    assign reg_addr  = in_regs ? 5'(index_next) : '0;
    assign mem_addr  = in_regs ? '0 : word_t'(mem_index) << 2;  // byte address
    assign last_word = (index == idx_w'(total_words - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else begin
            index <= index_next;
        end
    end

    always_ff @(posedge clk) begin
        collected_word <= in_regs ? reg_data : mem_data;
    end

    a_no_next_after_last: assert property (@(posedge clk) disable iff (reset)
        collect_next |-> !last_word);

endmodule

/* verilog/debug_controller.sv */
`timescale 1ns/1ps

module debug_controller #(
    parameter int imem_depth    = 64,
    parameter int num_regs      = 32,
    parameter int num_mem_words = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  debug_pkg::byte_t              rx_data,
    input  logic                          rx_done,
    output logic                          tx_start,
    output debug_pkg::byte_t              tx_data,
    input  logic                          tx_busy,
    input  logic                          tx_done,
    output logic                          imem_we,
    output logic [$clog2(imem_depth)-1:0] imem_waddr,
    output debug_pkg::word_t              imem_wdata,
    input  logic                          halt,
    input  debug_pkg::word_t              pc,
    input  debug_pkg::word_t              latch_if_id,
    input  debug_pkg::word_t              latch_id_ex,
    input  debug_pkg::word_t              latch_ex_mem,
    input  debug_pkg::word_t              latch_mem_wb,
    output logic                          cpu_reset,
    output logic                          cpu_enable,
    input  debug_pkg::word_t              collected_word,
    input  logic                          last_word,
    output logic                          collect_next,
    output logic                          collect_restart
);

    import debug_pkg::*;

    localparam int header_bytes = dump_header_words * 4;
    localparam int total_bytes  = (dump_header_words + num_regs + num_mem_words) * 4;
    localparam int bi_w         = $clog2(total_bytes);

    typedef enum logic [2:0] {
        s_idle,
        s_programming,
        s_waiting,
        s_step_mode,
        s_running,
        s_sending
    } dbg_state_t;

    dbg_state_t      state;
    logic [1:0]      byte_cnt;   // programming sub-count
    word_t           instr;
    word_t           cycles;
    logic [bi_w-1:0] byte_idx;   // dump byte
    logic            step_en;
    logic            word_end;
    logic            last_byte;
    word_t           dump_word;

    assign cpu_reset  = (state == s_waiting);
    assign cpu_enable = step_en || (state == s_running && !halt);
    assign imem_wdata = instr;

    ////////////////////////////////
    // dump byte select
    ////////////////////////////////

    always_comb begin
        case (byte_idx[bi_w-1:2])
            0:       dump_word = pc;
            1:       dump_word = latch_if_id;
            2:       dump_word = latch_id_ex;
            3:       dump_word = latch_ex_mem;
            4:       dump_word = latch_mem_wb;
            5:       dump_word = cycles;
            default: dump_word = collected_word;
        endcase
    end

    assign tx_data   = dump_word[{byte_idx[1:0], 3'b000} +: 8];  // lsb first
    assign word_end  = (byte_idx[1:0] == 2'd3) && (byte_idx >= bi_w'(header_bytes));
    assign last_byte = word_end && last_word;

    ////////////////////////////////
    // command fsm
    ////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= s_idle;
            byte_cnt        <= '0;
            imem_we         <= 1'b0;
            imem_waddr      <= '0;
            step_en         <= 1'b0;
            byte_idx        <= '0;
            tx_start        <= 1'b0;
            collect_next    <= 1'b0;
            collect_restart <= 1'b0;
        end else begin
            imem_we         <= 1'b0;
            tx_start        <= 1'b0;
            collect_next    <= 1'b0;
            collect_restart <= 1'b0;
            case (state)
                s_idle: begin
                    if (rx_done && rx_data == cmd_start) begin
                        state      <= s_programming;
                        byte_cnt   <= '0;
                        imem_waddr <= '0;
                    end
                end
                s_programming: begin
                    if (rx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        imem_we  <= (byte_cnt == 2'd3);
                    end
                    if (imem_we) begin
                        imem_waddr <= imem_waddr + 1'b1;
                        if (instr[31:26] == halt_opcode) begin
                            state <= s_waiting;
                        end
                    end
                end
                s_waiting: begin
                    if (rx_done) begin
                        case (rx_data)
                            cmd_reprogram:  state <= s_idle;
                            cmd_continuous: state <= s_running;
                            cmd_step_mode:  state <= s_step_mode;
                            default:        state <= s_waiting;
                        endcase
                    end
                end
                s_step_mode: begin
                    if (step_en) begin
                        step_en  <= 1'b0;
                        state    <= s_sending;
                        byte_idx <= '0;
                        tx_start <= 1'b1;
                    end else if (rx_done && rx_data == cmd_step) begin
                        step_en <= 1'b1;
                    end
                end
                s_running: begin
                    if (halt) begin
                        state    <= s_sending;
                        byte_idx <= '0;
                        tx_start <= 1'b1;
                    end
                end
                default: begin
                    if (tx_done) begin
                        if (last_byte) begin
                            collect_restart <= 1'b1;
                            byte_idx        <= '0;
                            state           <= halt ? s_waiting : s_step_mode;
                        end else begin
                            byte_idx     <= byte_idx + 1'b1;
                            collect_next <= word_end;
                            tx_start     <= !word_end;  // wait for the new word
                        end
                    end else if (collect_next && !tx_busy) begin
                        tx_start <= 1'b1;
                    end
                end
            endcase
        end
    end

    // instruction assembly, lsb first
    always_ff @(posedge clk) begin
        if (state == s_programming && rx_done) begin
            instr <= {rx_data, instr[31:8]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles <= '0;
        end else if (state == s_waiting) begin
            cycles <= '0;
        end else if (cpu_enable) begin
            cycles <= cycles + 1'b1;
        end
    end

    a_frozen_while_sending: assert property (@(posedge clk) disable iff (reset)
        state == s_sending |-> !cpu_enable);

    a_write_only_programming: assert property (@(posedge clk) disable iff (reset)
        imem_we |-> state == s_programming);

endmodule

/* verilog/mips_debug_unit.sv */
`timescale 1ns/1ps

module mips_debug_unit #(
    parameter int clks_per_bit  = 868,
    parameter int num_regs      = 32,
    parameter int num_mem_words = 16,
    parameter int imem_depth    = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          uart_rx_line,
    output logic                          uart_tx_line,
    input  logic                          halt,
    input  debug_pkg::word_t              pc,
    input  debug_pkg::word_t              latch_if_id,
    input  debug_pkg::word_t              latch_id_ex,
    input  debug_pkg::word_t              latch_ex_mem,
    input  debug_pkg::word_t              latch_mem_wb,
    output logic [4:0]                    reg_addr,
    input  debug_pkg::word_t              reg_data,
    output debug_pkg::word_t              mem_addr,
    input  debug_pkg::word_t              mem_data,
    input  logic [$clog2(imem_depth)-1:0] imem_raddr,
    output debug_pkg::word_t              imem_rdata,
    output logic                          cpu_reset,
    output logic                          cpu_enable
);

    import debug_pkg::*;

    byte_t                         rx_data;
    logic                          rx_done;
    byte_t                         tx_data;
    logic                          tx_start;
    logic                          tx_busy;
    logic                          tx_done;
    logic                          imem_we;
    logic [$clog2(imem_depth)-1:0] imem_waddr;
    word_t                         imem_wdata;
    word_t                         collected_word;
    logic                          last_word;
    logic                          collect_next;
    logic                          collect_restart;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_rx (
        .clk    (clk),
        .reset  (reset),
        .rx_line(uart_rx_line),
        .rx_data(rx_data),
        .rx_done(rx_done)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_tx (
        .clk     (clk),
        .reset   (reset),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx_line (uart_tx_line),
        .tx_busy (tx_busy),
        .tx_done (tx_done)
    );

    debug_controller #(
        .imem_depth   (imem_depth),
        .num_regs     (num_regs),
        .num_mem_words(num_mem_words)
    ) u_debug_controller (
        .clk            (clk),
        .reset          (reset),
        .rx_data        (rx_data),
        .rx_done        (rx_done),
        .tx_start       (tx_start),
        .tx_data        (tx_data),
        .tx_busy        (tx_busy),
        .tx_done        (tx_done),
        .imem_we        (imem_we),
        .imem_waddr     (imem_waddr),
        .imem_wdata     (imem_wdata),
        .halt           (halt),
        .pc             (pc),
        .latch_if_id    (latch_if_id),
        .latch_id_ex    (latch_id_ex),
        .latch_ex_mem   (latch_ex_mem),
        .latch_mem_wb   (latch_mem_wb),
        .cpu_reset      (cpu_reset),
        .cpu_enable     (cpu_enable),
        .collected_word (collected_word),
        .last_word      (last_word),
        .collect_next   (collect_next),
        .collect_restart(collect_restart)
    );

    state_collector #(
        .num_regs     (num_regs),
        .num_mem_words(num_mem_words)
    ) u_state_collector (
        .clk            (clk),
        .reset          (reset),
        .collect_restart(collect_restart),
        .collect_next   (collect_next),
        .reg_addr       (reg_addr),
        .reg_data       (reg_data),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .collected_word (collected_word),
        .last_word      (last_word)
    );

    program_memory #(
        .imem_depth(imem_depth)
    ) u_program_memory (
        .clk  (clk),
        .we   (imem_we),
        .waddr(imem_waddr),
        .wdata(imem_wdata),
        .raddr(imem_raddr),
        .rdata(imem_rdata)
    );

endmodule

/* dv/uart_host_tasks.svh */
`ifndef UART_HOST_TASKS_SVH
`define UART_HOST_TASKS_SVH

////////////////////////////////
// compare tasks
////////////////////////////////

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

////////////////////////////////
// host side of the uart
////////////////////////////////

task automatic send_byte(input byte_t data);
    @(negedge clk);
    uart_rx_line = 1'b0;  // start bit
    repeat (clks_per_bit) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
        uart_rx_line = data[i];  // lsb first
        repeat (clks_per_bit) @(negedge clk);
    end
    uart_rx_line = 1'b1;
    repeat (clks_per_bit) @(negedge clk);
endtask

task automatic receive_byte(output byte_t data);
    int waited;
    waited = 0;
    while (uart_tx_line !== 1'b0) begin
        if (waited >= rx_timeout) timeout_abort("no start bit from the DUT transmitter");
        @(negedge clk);
        waited++;
    end
    repeat (clks_per_bit / 2) @(negedge clk);  // centre of start bit
    check_bit("uart_tx_line start bit", uart_tx_line, 1'b0);
    for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        data[i] = uart_tx_line;
    end
    repeat (clks_per_bit) @(negedge clk);
    check_bit("uart_tx_line stop bit", uart_tx_line, 1'b1);
endtask

`endif

/* dv/debug_unit_tb.sv */
`timescale 1ns/1ps

module debug_unit_tb;

    import debug_pkg::*;

    localparam int clks_per_bit  = 16;
    localparam int num_regs      = 8;
    localparam int num_mem_words = 4;
    localparam int imem_depth    = 64;
    localparam int dump_bytes    = (dump_header_words + num_regs + num_mem_words) * 4;
    localparam int rx_timeout    = 4000;  // clocks

    logic                          clk;
    logic                          reset;
    logic                          uart_rx_line;
    logic                          uart_tx_line;
    logic                          halt;
    word_t                         pc;
    word_t                         latch_if_id;
    word_t                         latch_id_ex;
    word_t                         latch_ex_mem;
    word_t                         latch_mem_wb;
    logic [4:0]                    reg_addr;
    word_t                         reg_data;
    word_t                         mem_addr;
    word_t                         mem_data;
    logic [$clog2(imem_depth)-1:0] imem_raddr;
    word_t                         imem_rdata;
    logic                          cpu_reset;
    logic                          cpu_enable;

    int    errors       = 0;
    int    core_cycles  = 0;  // cleared while the core is held in reset
    int    enable_total = 0;
    int    reset_total  = 0;
    word_t prog_words[6];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////
    // core model
    ////////////////////////////////

    assign pc       = word_t'(core_cycles) * 4;
    assign reg_data = word_t'(reg_addr) * 32'h01010101;
    assign mem_data = mem_addr + 32'h1000;

    always @(posedge clk) begin
        if (cpu_reset) begin
            core_cycles <= 0;
            reset_total <= reset_total + 1;
        end else if (cpu_enable) begin
            core_cycles <= core_cycles + 1;
        end
        if (cpu_enable) enable_total <= enable_total + 1;
    end

    mips_debug_unit #(
        .clks_per_bit (clks_per_bit),
        .num_regs     (num_regs),
        .num_mem_words(num_mem_words),
        .imem_depth   (imem_depth)
    ) u_mips_debug_unit (
        .clk         (clk),
        .reset       (reset),
        .uart_rx_line(uart_rx_line),
        .uart_tx_line(uart_tx_line),
        .halt        (halt),
        .pc          (pc),
        .latch_if_id (latch_if_id),
        .latch_id_ex (latch_id_ex),
        .latch_ex_mem(latch_ex_mem),
        .latch_mem_wb(latch_mem_wb),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .imem_raddr  (imem_raddr),
        .imem_rdata  (imem_rdata),
        .cpu_reset   (cpu_reset),
        .cpu_enable  (cpu_enable)
    );

    task automatic finish_run();
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("timeout: %s", what);
        finish_run();
    endtask

    `include "uart_host_tasks.svh"

    ////////////////////////////////
    // dump and program helpers
    ////////////////////////////////

    // header words, then registers, then data memory
    function automatic word_t expected_word(input int idx, input word_t cycles);
        case (idx)
            0: return cycles * 4;  // pc
            1: return latch_if_id;
            2: return latch_id_ex;
            3: return latch_ex_mem;
            4: return latch_mem_wb;
            5: return cycles;
            default: begin
                if (idx < dump_header_words + num_regs)
                    return word_t'(idx - dump_header_words) * 32'h01010101;
                return word_t'(idx - dump_header_words - num_regs) * 4 + 32'h1000;
            end
        endcase
    endfunction

    task automatic receive_and_check_dump(input word_t cycles);
        byte_t got;
        word_t exp;
        for (int i = 0; i < dump_bytes; i++) begin
            receive_byte(got);
            exp = expected_word(i / 4, cycles);
            check_byte($sformatf("dump byte %0d", i), got, exp[8 * (i % 4) +: 8]);
        end
    endtask

    task automatic wait_for_cpu_reset();
        int waited;
        waited = 0;
        while (cpu_reset !== 1'b1) begin
            if (waited >= rx_timeout) timeout_abort("cpu_reset never went high");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic make_program(input int count);
        for (int w = 0; w < count - 1; w++) begin
            prog_words[w]     = $urandom;
            prog_words[w][31] = 1'b0;  // keeps the opcode off halt
        end
        prog_words[count - 1] = {halt_opcode, 26'($urandom)};
    endtask

    task automatic load_program(input int count);
        send_byte(cmd_start);
        for (int w = 0; w < count; w++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(prog_words[w][8 * b +: 8]);
            end
        end
        wait_for_cpu_reset();
        // read back through the core fetch port
        for (int w = 0; w < count; w++) begin
            imem_raddr = w[$clog2(imem_depth)-1:0];
            @(negedge clk);
            check_word($sformatf("imem_rdata[%0d]", w), imem_rdata, prog_words[w]);
        end
        check_bit("cpu_reset", cpu_reset, 1'b1);
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////

    task automatic idle_after_reset();
        int enables_before;
        int resets_before;
        check_bit("uart_tx_line", uart_tx_line, 1'b1);
        check_bit("cpu_reset", cpu_reset, 1'b0);
        check_bit("cpu_enable", cpu_enable, 1'b0);
        enables_before = enable_total;
        resets_before  = reset_total;
        send_byte(8'ha5);  // no such command
        repeat (clks_per_bit) @(negedge clk);
        check_word("cpu_enable cycles", word_t'(enable_total - enables_before), '0);
        check_word("cpu_reset cycles", word_t'(reset_total - resets_before), '0);
    endtask

    task automatic program_and_read_back();
        make_program(6);
        load_program(6);
    endtask

    task automatic step_three_times();
        int enables_before;
        send_byte(cmd_step_mode);
        repeat (clks_per_bit) @(negedge clk);
        for (int s = 1; s <= 3; s++) begin
            enables_before = enable_total;
            halt = (s == 3);  // third instruction halts
            fork
                send_byte(cmd_step);
                receive_and_check_dump(word_t'(s));
            join
            check_word("cpu_enable cycles per step", word_t'(enable_total - enables_before), 1);
            repeat (clks_per_bit) @(negedge clk);
        end
        wait_for_cpu_reset();
        halt = 1'b0;
    endtask

    task automatic run_until_halt();
        int    target;
        int    waited;
        int    enables_before;
        word_t counted;
        target         = 3 + ($urandom % 10);
        enables_before = enable_total;
        waited         = 0;
        fork
            send_byte(cmd_continuous);
            begin
                while (core_cycles < target) begin
                    if (waited >= rx_timeout) timeout_abort("core never ran in continuous mode");
                    @(negedge clk);
                    waited++;
                end
                halt    = 1'b1;
                counted = word_t'(enable_total - enables_before);
                receive_and_check_dump(counted);
            end
        join
        check_word("cpu_enable cycles", word_t'(enable_total - enables_before), counted);
        wait_for_cpu_reset();
        repeat (clks_per_bit) @(negedge clk);
        check_bit("cpu_reset", cpu_reset, 1'b1);  // still waiting
        halt = 1'b0;
    endtask

    task automatic reprogram_shorter();
        send_byte(cmd_reprogram);
        repeat (clks_per_bit) @(negedge clk);
        check_bit("cpu_reset", cpu_reset, 1'b0);  // back in idle
        make_program(3);
        load_program(3);
    endtask

    initial begin
        void'($urandom(32'h70a30966));
        reset        = 1'b1;
        uart_rx_line = 1'b1;
        halt         = 1'b0;
        imem_raddr   = '0;
        latch_if_id  = $urandom;
        latch_id_ex  = $urandom;
        latch_ex_mem = $urandom;
        latch_mem_wb = $urandom;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        idle_after_reset();
        program_and_read_back();
        step_three_times();
        run_until_halt();
        reprogram_shorter();
        finish_run();
    end

endmodule

/* mips_debug.f */
+incdir+dv
verilog/debug_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/program_memory.sv
verilog/state_collector.sv
verilog/debug_controller.sv
verilog/mips_debug_unit.sv
dv/debug_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f mips_debug.f \
    --top-module debug_unit_tb -o sim_debug_unit \
    && ./obj_dir/sim_debug_unit | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
